//--- include/des_regs.svh
`ifndef DES_REGS_SVH
`define DES_REGS_SVH

`define REG_KEY_LO      8'h00
`define REG_KEY_HI      8'h04
`define REG_DIN_LO      8'h08
`define REG_DIN_HI      8'h0C
`define REG_CTRL        8'h10
`define REG_STATUS      8'h14
`define REG_DOUT_LO     8'h18
`define REG_DOUT_HI     8'h1C

`define CTRL_START_BIT  0
`define STATUS_BUSY_BIT 0
`define STATUS_DONE_BIT 1

`endif

//--- hw/des_pkg.sv
package des_pkg;

    localparam int BLOCK_W    = 64;
    localparam int KEY_W      = 64;
    localparam int HALF_W     = 32;
    localparam int SUBKEY_W   = 48;
    localparam int CD_W       = 28;
    localparam int NUM_ROUNDS = 16;

    typedef logic [BLOCK_W-1:0]  des_block_t;
    typedef logic [SUBKEY_W-1:0] des_subkey_t;

    typedef struct packed {
        logic [KEY_W-1:0] key;
        des_block_t       block;
    } des_job_t;

    typedef struct packed {
        logic busy;
        logic done;
    } des_status_t;

    // standard DES numbering, entry 1 is the msb
    localparam int IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int E_TAB [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int P_TAB [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    localparam int PC1_TAB [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam int PC2_TAB [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // one nibble per entry, row 0 column 0 in the top nibble
    localparam logic [255:0] SBOX_TAB [8] = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

    function automatic des_block_t des_ip(input des_block_t x);
        des_block_t y;
        for (int i = 0; i < BLOCK_W; i++)
            y[BLOCK_W-1-i] = x[BLOCK_W-IP_TAB[i]];
        return y;
    endfunction

    // inverse of IP, built from the same table
    function automatic des_block_t des_fp(input des_block_t x);
        des_block_t y;
        for (int i = 0; i < BLOCK_W; i++)
            y[BLOCK_W-IP_TAB[i]] = x[BLOCK_W-1-i];
        return y;
    endfunction

    function automatic des_subkey_t des_expand(input logic [HALF_W-1:0] x);
        des_subkey_t y;
        for (int i = 0; i < SUBKEY_W; i++)
            y[SUBKEY_W-1-i] = x[HALF_W-E_TAB[i]];
        return y;
    endfunction

    function automatic logic [HALF_W-1:0] des_pbox(input logic [HALF_W-1:0] x);
        logic [HALF_W-1:0] y;
        for (int i = 0; i < HALF_W; i++)
            y[HALF_W-1-i] = x[HALF_W-P_TAB[i]];
        return y;
    endfunction

    function automatic logic [2*CD_W-1:0] des_pc1(input logic [KEY_W-1:0] x);
        logic [2*CD_W-1:0] y;
        for (int i = 0; i < 2*CD_W; i++)
            y[2*CD_W-1-i] = x[KEY_W-PC1_TAB[i]];
        return y;
    endfunction

    function automatic des_subkey_t des_pc2(input logic [2*CD_W-1:0] x);
        des_subkey_t y;
        for (int i = 0; i < SUBKEY_W; i++)
            y[SUBKEY_W-1-i] = x[2*CD_W-PC2_TAB[i]];
        return y;
    endfunction

    function automatic logic [HALF_W-1:0] des_sbox(input des_subkey_t x);
        logic [HALF_W-1:0] y;
        logic [5:0]        grp;
        logic [5:0]        idx;
        for (int s = 0; s < 8; s++)
        begin
            grp = x[SUBKEY_W-1-6*s -: 6];
            // row from the outer bits, column from the inner four
            idx = {grp[5], grp[0], grp[4:1]};
            y[HALF_W-1-4*s -: 4] = SBOX_TAB[s][255-4*idx -: 4];
        end
        return y;
    endfunction

    // encryption shift amount for rounds 1 to 16
    function automatic int des_shift(input logic [4:0] round);
        case (round)
            5'd1, 5'd2, 5'd9, 5'd16: return 1;
            default: return 2;
        endcase
    endfunction

endpackage

//--- hw/des_key_schedule.sv
`timescale 1ns/100ps

module des_key_schedule
    import des_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic             advance,
    input  logic [4:0]       round,
    input  logic [KEY_W-1:0] key,
    output des_subkey_t      subkey
);

    logic [CD_W-1:0]   c_q;
    logic [CD_W-1:0]   d_q;
    logic [2*CD_W-1:0] pc1_key;
    logic [4:0]        mirror_round;

    assign pc1_key = des_pc1(key);

    // decryption walks the encryption schedule backwards
    assign mirror_round = 5'd17 - round;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            c_q <= '0;
            d_q <= '0;
        end
        else if (load)
        begin
            c_q <= pc1_key[2*CD_W-1:CD_W];
            d_q <= pc1_key[CD_W-1:0];
        end
        else if (advance)
        begin
            if (des_shift(mirror_round) == 1)
            begin
                c_q <= {c_q[0], c_q[CD_W-1:1]};
                d_q <= {d_q[0], d_q[CD_W-1:1]};
            end
            else
            begin
                c_q <= {c_q[1:0], c_q[CD_W-1:2]};
                d_q <= {d_q[1:0], d_q[CD_W-1:2]};
            end
        end
    end

    assign subkey = des_pc2({c_q, d_q});

endmodule

//--- hw/des_feistel_datapath.sv
`timescale 1ns/100ps

module des_feistel_datapath
    import des_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic        advance,
    input  des_block_t  block,
    input  des_subkey_t subkey,
    output des_block_t  text
);

    logic [HALF_W-1:0] l_q;
    logic [HALF_W-1:0] r_q;
    logic [HALF_W-1:0] f_out;
    logic [HALF_W-1:0] r_next;
    des_block_t        ip_block;

    assign ip_block = des_ip(block);

    // expansion, key mix, s-boxes, then P
    assign f_out  = des_pbox(des_sbox(des_expand(r_q) ^ subkey));
    assign r_next = l_q ^ f_out;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            l_q <= '0;
            r_q <= '0;
        end
        else if (load)
        begin
            l_q <= ip_block[BLOCK_W-1:HALF_W];
            r_q <= ip_block[HALF_W-1:0];
        end
        else if (advance)
        begin
            l_q <= r_q;
            r_q <= r_next;
        end
    end

    // taken from the round in flight, so the last round edge
    // can capture the finished block directly
    assign text = des_fp({r_next, r_q});

endmodule

//--- hw/des_decrypt_engine.sv
`timescale 1ns/100ps

module des_decrypt_engine
    import des_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  des_job_t    job,
    output des_status_t status,
    output des_block_t  result
);

    logic        busy_q;
    logic        done_q;
    logic [4:0]  round_q;
    logic        last_round;
    des_block_t  result_q;
    des_subkey_t subkey;
    des_block_t  text;

    assign last_round = busy_q && (round_q == 5'(NUM_ROUNDS));

    des_key_schedule u_key_schedule (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (start),
        .advance (busy_q),
        .round   (round_q),
        .key     (job.key),
        .subkey  (subkey)
    );

    des_feistel_datapath u_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (start),
        .advance (busy_q),
        .block   (job.block),
        .subkey  (subkey),
        .text    (text)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            round_q  <= '0;
            result_q <= '0;
        end
        else if (start)
        begin
            busy_q  <= 1'b1;
            done_q  <= 1'b0;
            round_q <= 5'd1;
        end
        else if (last_round)
        begin
            busy_q   <= 1'b0;
            done_q   <= 1'b1;
            round_q  <= '0;
            result_q <= text;
        end
        else if (busy_q)
            round_q <= round_q + 5'd1;
    end

    assign status = '{busy: busy_q, done: done_q};
    assign result = result_q;

endmodule

//--- hw/des_apb_regs.sv
`timescale 1ns/100ps
`include "des_regs.svh"

module des_apb_regs
    import des_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  start,
    output des_job_t              job,
    input  des_status_t           status,
    input  des_block_t            result
);

    logic [31:0] key_lo_q;
    logic [31:0] key_hi_q;
    logic [31:0] din_lo_q;
    logic [31:0] din_hi_q;
    logic [31:0] rdata;
    logic        addr_hit;
    logic        access;
    logic        wr_en;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    // address decode and read mux
    always_comb
    begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (paddr)
            ADDR_WIDTH'(`REG_KEY_LO):  rdata = key_lo_q;
            ADDR_WIDTH'(`REG_KEY_HI):  rdata = key_hi_q;
            ADDR_WIDTH'(`REG_DIN_LO):  rdata = din_lo_q;
            ADDR_WIDTH'(`REG_DIN_HI):  rdata = din_hi_q;
            ADDR_WIDTH'(`REG_CTRL):    rdata = '0;
            ADDR_WIDTH'(`REG_STATUS):
            begin
                rdata[`STATUS_BUSY_BIT] = status.busy;
                rdata[`STATUS_DONE_BIT] = status.done;
            end
            ADDR_WIDTH'(`REG_DOUT_LO): rdata = result[31:0];
            ADDR_WIDTH'(`REG_DOUT_HI): rdata = result[63:32];
            default:                   addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            key_lo_q <= '0;
            key_hi_q <= '0;
            din_lo_q <= '0;
            din_hi_q <= '0;
        end
        else if (wr_en)
        begin
            case (paddr)
                ADDR_WIDTH'(`REG_KEY_LO): key_lo_q <= pwdata;
                ADDR_WIDTH'(`REG_KEY_HI): key_hi_q <= pwdata;
                ADDR_WIDTH'(`REG_DIN_LO): din_lo_q <= pwdata;
                ADDR_WIDTH'(`REG_DIN_HI): din_hi_q <= pwdata;
                default: ;
            endcase
        end
    end

    // read data sampled at the end of setup, held through access
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            prdata <= '0;
        else if (psel && !penable && !pwrite)
            prdata <= rdata;
    end

    // starts while the engine runs are dropped here
    assign start = wr_en && (paddr == ADDR_WIDTH'(`REG_CTRL))
                   && pwdata[`CTRL_START_BIT] && !status.busy;

    assign job     = '{key: {key_hi_q, key_lo_q}, block: {din_hi_q, din_lo_q}};
    assign pready  = 1'b1;
    assign pslverr = access && !addr_hit;

endmodule

//--- hw/des_apb_top.sv
`timescale 1ns/100ps

module des_apb_top
    import des_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic        start;
    des_job_t    job;
    des_status_t status;
    des_block_t  result;

    des_apb_regs #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .job     (job),
        .status  (status),
        .result  (result)
    );

    des_decrypt_engine u_engine (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .job    (job),
        .status (status),
        .result (result)
    );

endmodule

//--- verification/des_properties.sv
`timescale 1ns/100ps

module des_properties
(
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);

    logic [4:0] busy_cycles;

    // length of the current busy run
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            busy_cycles <= '0;
        else if (busy)
            busy_cycles <= busy_cycles + 5'd1;
        else
            busy_cycles <= '0;
    end

    busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
        else $error("busy and done high together");

    // one load edge, then sixteen round edges
    busy_run_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> busy_cycles == 5'd16)
        else $error("busy run lasted %0d cycles", busy_cycles);

    busy_run_limit: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> busy_cycles < 5'd16)
        else $error("busy held past sixteen cycles");

    done_held_until_start: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> done)
        else $error("done dropped without a start");

endmodule

bind des_decrypt_engine des_properties u_properties (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy_q),
    .done  (done_q)
);

//--- verification/des_tb.sv
`timescale 1ns/100ps
`include "des_regs.svh"

module des_tb
    import des_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer seed;
    int     errors;
    int     checks;
    logic   last_slverr;

    des_apb_top #(
        .ADDR_WIDTH (8)
    ) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // setup cycle, access cycle, then one idle cycle
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        last_slverr = pslverr;
        expect_word("pready", 32'(pready), 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // mid access cycle, prdata and pslverr are settled
        @(negedge clk);
        data        = prdata;
        last_slverr = pslverr;
        expect_word("pready", 32'(pready), 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_job(input logic [63:0] key, input logic [63:0] block);
        write_reg(`REG_KEY_LO, key[31:0]);
        write_reg(`REG_KEY_HI, key[63:32]);
        write_reg(`REG_DIN_LO, block[31:0]);
        write_reg(`REG_DIN_HI, block[63:32]);
    endtask

    task automatic read_result(output logic [63:0] res);
        logic [31:0] lo;
        logic [31:0] hi;
        read_reg(`REG_DOUT_LO, lo);
        read_reg(`REG_DOUT_HI, hi);
        res = {hi, lo};
    endtask

    task automatic wait_done();
        logic [31:0] stat;
        int          polls;
        stat  = '0;
        polls = 0;
        while (!stat[`STATUS_DONE_BIT] && polls < 100)
        begin
            read_reg(`REG_STATUS, stat);
            polls++;
        end
        checks++;
        if (!stat[`STATUS_DONE_BIT])
        begin
            $display("timeout: done did not rise within 100 STATUS polls");
            errors++;
        end
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got != exp)
        begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic expect_block(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        checks++;
        if (got != exp)
        begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // round keys built forward with left rotations, used in reverse
    function automatic logic [63:0] decrypt_model(input logic [63:0] key,
                                                  input logic [63:0] ct);
        logic [2*CD_W-1:0] cd;
        logic [CD_W-1:0]   c;
        logic [CD_W-1:0]   d;
        des_subkey_t       ks [NUM_ROUNDS];
        logic [63:0]       ipb;
        logic [31:0]       l;
        logic [31:0]       r;
        logic [31:0]       t;
        cd = des_pc1(key);
        c  = cd[2*CD_W-1:CD_W];
        d  = cd[CD_W-1:0];
        for (int i = 0; i < NUM_ROUNDS; i++)
        begin
            for (int k = 0; k < des_shift(5'(i + 1)); k++)
            begin
                c = {c[CD_W-2:0], c[CD_W-1]};
                d = {d[CD_W-2:0], d[CD_W-1]};
            end
            ks[i] = des_pc2({c, d});
        end
        ipb = des_ip(ct);
        l   = ipb[63:32];
        r   = ipb[31:0];
        for (int i = 0; i < NUM_ROUNDS; i++)
        begin
            t = r;
            r = l ^ des_pbox(des_sbox(des_expand(r) ^ ks[NUM_ROUNDS-1-i]));
            l = t;
        end
        return des_fp({r, l});
    endfunction

    initial
    begin
        logic [63:0] key_a;
        logic [63:0] ct_a;
        logic [63:0] ct_b;
        logic [63:0] res;
        logic [31:0] rd;

        seed        = 32'h2b65;
        errors      = 0;
        checks      = 0;
        last_slverr = 1'b0;
        rst_n       = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values and key readback
        read_reg(`REG_STATUS, rd);
        expect_word("STATUS", rd, 32'h0);
        read_reg(`REG_DOUT_LO, rd);
        expect_word("DOUT_LO", rd, 32'h0);
        read_reg(`REG_DOUT_HI, rd);
        expect_word("DOUT_HI", rd, 32'h0);
        write_reg(`REG_KEY_LO, 32'h1357_9bdf);
        write_reg(`REG_KEY_HI, 32'h2468_ace0);
        read_reg(`REG_KEY_LO, rd);
        expect_word("KEY_LO", rd, 32'h1357_9bdf);
        checks++;
        if (last_slverr)
        begin
            $display("pslverr rose on a read of a mapped register");
            errors++;
        end
        read_reg(`REG_KEY_HI, rd);
        expect_word("KEY_HI", rd, 32'h2468_ace0);

        // known answer, which also guards the package tables
        expect_block("model", decrypt_model(64'h1334_5779_9bbc_dff1, 64'h85e8_1354_0f0a_b405),
                     64'h0123_4567_89ab_cdef);
        load_job(64'h1334_5779_9bbc_dff1, 64'h85e8_1354_0f0a_b405);
        write_reg(`REG_CTRL, 32'h1);
        // CTRL holds no state even right after a start
        read_reg(`REG_CTRL, rd);
        expect_word("CTRL", rd, 32'h0);
        read_reg(`REG_STATUS, rd);
        expect_word("STATUS", rd, 32'h1);
        wait_done();
        read_reg(`REG_STATUS, rd);
        expect_word("STATUS", rd, 32'h2);
        read_result(res);
        expect_block("DOUT", res, 64'h0123_4567_89ab_cdef);

        // random jobs, done must clear on each new start
        for (int i = 0; i < 40; i++)
        begin
            key_a = {$random(seed), $random(seed)};
            ct_a  = {$random(seed), $random(seed)};
            load_job(key_a, ct_a);
            write_reg(`REG_CTRL, 32'h1);
            read_reg(`REG_STATUS, rd);
            expect_word("STATUS", rd, 32'h1);
            wait_done();
            read_result(res);
            expect_block("DOUT", res, decrypt_model(key_a, ct_a));
        end

        // second start while busy is dropped
        key_a = {$random(seed), $random(seed)};
        ct_a  = {$random(seed), $random(seed)};
        ct_b  = {$random(seed), $random(seed)};
        load_job(key_a, ct_a);
        write_reg(`REG_CTRL, 32'h1);
        write_reg(`REG_DIN_LO, ct_b[31:0]);
        write_reg(`REG_DIN_HI, ct_b[63:32]);
        write_reg(`REG_CTRL, 32'h1);
        wait_done();
        read_result(res);
        expect_block("DOUT", res, decrypt_model(key_a, ct_a));
        write_reg(`REG_CTRL, 32'h1);
        wait_done();
        read_result(res);
        expect_block("DOUT", res, decrypt_model(key_a, ct_b));

        // unmapped address
        read_reg(8'h40, rd);
        checks++;
        if (!last_slverr)
        begin
            $display("pslverr stayed low on a read of unmapped address 0x40");
            errors++;
        end
        expect_word("prdata", rd, 32'h0);
        write_reg(8'h40, 32'hdead_beef);
        checks++;
        if (!last_slverr)
        begin
            $display("pslverr stayed low on a write to unmapped address 0x40");
            errors++;
        end
        read_reg(`REG_KEY_LO, rd);
        expect_word("KEY_LO", rd, key_a[31:0]);
        read_reg(`REG_KEY_HI, rd);
        expect_word("KEY_HI", rd, key_a[63:32]);
        read_reg(`REG_DIN_LO, rd);
        expect_word("DIN_LO", rd, ct_b[31:0]);
        read_reg(`REG_DIN_HI, rd);
        expect_word("DIN_HI", rd, ct_b[63:32]);
        read_reg(`REG_STATUS, rd);
        expect_word("STATUS", rd, 32'h2);
        read_result(res);
        expect_block("DOUT", res, decrypt_model(key_a, ct_b));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hw/des_pkg.sv
hw/des_key_schedule.sv
hw/des_feistel_datapath.sv
hw/des_decrypt_engine.sv
hw/des_apb_regs.sv
hw/des_apb_top.sv
verification/des_properties.sv
verification/des_tb.sv

//--- Makefile
TOP = des_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
